// ==== build.f ====
tetrisPkg.sv
pieceGen.sv
pieceDrop.sv
lineClear.sv
gameCtrl.sv
wbRegs.sv
tetrisTop.sv
tb_tetrisTop.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_tetrisTop -f build.f -o simTetris
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simTetris)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_tetrisTop.sv ====
`timescale 1ns/10ps

module tb_tetrisTop import tetrisPkg::*; ();

    logic clk, rst, cyc, stb, we, ack;
    logic [5:0] adr;
    logic [31:0] datW, datR;

    logic [9:0] mBoard [0:19]; // Model stack with column 0 in bit 9
    int mPiece, mRow, mCol, mLines;
    logic [15:0] mLfsr;
    bit mOver, mLocked;

    tetrisTop i_tetrisTop (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Shape boxes of four rows by four cells read left to right
    function automatic bit shapeCell(int p, int r, int c);
        logic [15:0] s;
        case (p)
            0: s = 16'h8888; // Vertical line
            1: s = 16'hCC00;
            2: s = 16'h88C0;
            3: s = 16'h44C0;
            4: s = 16'h6C00;
            5: s = 16'hC600;
            default: s = 16'h4E00;
        endcase
        s = s << (4 * r + c);
        return s[15];
    endfunction

    function automatic bit fitsAt(int p, int row, int col);
        bit ok;
        int br;
        int bc;
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = row + r;
                bc = col + c;
                if (!shapeCell(p, r, c)) continue;
                if (br >= 20 || bc < 0 || bc >= 10) ok = 1'b0;
                else if ((mBoard[br] & (10'h200 >> bc)) != 10'h0) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Stack plus the falling piece as the host sees a row
    function automatic logic [9:0] viewRow(int r);
        logic [9:0] v;
        int sr;
        v = mBoard[r];
        sr = r - mRow;
        if (sr >= 0 && sr < 4) begin
            for (int c = 0; c < 4; c++) begin
                if (shapeCell(mPiece, sr, c)) v = v | (10'h200 >> (mCol + c));
            end
        end
        return v;
    endfunction

    function automatic void spawnModel();
        logic outBit;
        mPiece = int'(mLfsr[2:0]);
        if (mPiece == 7) mPiece = 0; // Code 7 stands for the line
        outBit = mLfsr[0];
        mLfsr = mLfsr >> 1;
        if (outBit) mLfsr = mLfsr ^ lfsrTaps;
        mRow = 0;
        mCol = int'(spawnCol);
        mOver = !fitsAt(mPiece, 0, mCol);
    endfunction

    function automatic void restartModel();
        foreach (mBoard[r]) mBoard[r] = 10'h000;
        mLines = 0;
        mLfsr = lfsrSeed;
        spawnModel();
    endfunction

    // Piece into the stack and then full rows squeezed out bottom up
    function automatic void lockModel();
        int dst;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (shapeCell(mPiece, r, c)) mBoard[mRow + r] |= 10'h200 >> (mCol + c);
            end
        end
        dst = 19;
        for (int r = 19; r >= 0; r--) begin
            if (mBoard[r] == 10'h3FF) begin
                mLines++;
            end else begin
                mBoard[dst] = mBoard[r];
                dst--;
            end
        end
        while (dst >= 0) begin
            mBoard[dst] = 10'h000;
            dst--;
        end
    endfunction

    task automatic failRun(string why);
        $display("%s at %0t ns", why, $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkEqual(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // One Wishbone classic access that starts and ends on a falling edge
    task automatic busCycle(logic [5:0] a, logic isWrite, logic [31:0] wd,
                            output logic [31:0] rd);
        int waited;
        adr = a;
        we = isWrite;
        datW = wd;
        cyc = 1'b1;
        stb = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 10) failRun("slave never raised ack");
        end while (!ack);
        rd = datR;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        @(negedge clk);
        if (ack) failRun("ack stayed high for a second cycle");
    endtask

    task automatic writeReg(logic [5:0] a, logic [31:0] d);
        logic [31:0] unused;
        busCycle(a, 1'b1, d, unused);
    endtask

    task automatic readReg(logic [5:0] a, output logic [31:0] d);
        busCycle(a, 1'b0, 32'h0, d);
    endtask

    task automatic waitIdle();
        logic [31:0] st;
        int polls;
        polls = 0;
        do begin
            readReg(regStatus, st);
            polls++;
            if (polls > 200) failRun("busy never dropped after lock or restart");
        end while (st[0]);
    endtask

    task automatic checkAll();
        logic [31:0] got;
        logic [31:0] exp;
        exp = 32'h0;
        exp[1] = mOver;
        exp[4:2] = 3'(mPiece);
        exp[12:8] = 5'(mRow);
        exp[20:16] = 5'(mCol);
        readReg(regStatus, got);
        checkEqual("status", got, exp);
        readReg(regLines, got);
        checkEqual("lines", got, 32'(mLines));
        for (int r = 0; r < 20; r++) begin
            readReg(regRowBase + 6'(r), got);
            checkEqual($sformatf("row %0d", r), got, {22'h0, viewRow(r)});
        end
    endtask

    task automatic checkUnmapped();
        logic [5:0] holes [0:5];
        logic [31:0] got;
        holes = '{6'd1, 6'd3, 6'd17, 6'd31, 6'd52, 6'd63};
        foreach (holes[i]) begin
            readReg(holes[i], got);
            checkEqual($sformatf("unmapped adr %0d", holes[i]), got, 32'h0);
        end
    endtask

    // kind 0 is step, 1 left, 2 right
    task automatic doCommand(int kind);
        logic [31:0] st;
        mLocked = 1'b0;
        writeReg(regCtrl, 32'h1 << kind);
        if (!mOver) begin
            case (kind)
                0: begin
                    if (fitsAt(mPiece, mRow + 1, mCol)) mRow++;
                    else mLocked = 1'b1;
                end
                1: if (fitsAt(mPiece, mRow, mCol - 1)) mCol--;
                default: if (fitsAt(mPiece, mRow, mCol + 1)) mCol++;
            endcase
        end
        if (mLocked) begin
            readReg(regStatus, st);
            checkEqual("busy after lock", {31'h0, st[0]}, 32'h1);
            lockModel();
            spawnModel();
            waitIdle();
        end
        checkAll();
    endtask

    initial begin
        int target;
        int kind;
        int games;
        void'($urandom(32'h5d4c));
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 6'h00;
        datW = 32'h0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        restartModel();
        waitIdle();
        checkAll();
        checkUnmapped();

        games = 0;
        target = int'($urandom % 10);
        for (int n = 0; n < 3000; n++) begin
            if (mOver) begin
                // Dead game ignores everything but restart
                doCommand(0);
                doCommand(1);
                doCommand(2);
                writeReg(regCtrl, 32'h8);
                restartModel();
                waitIdle();
                checkAll();
                games++;
            end
            if ($urandom % 8 < 5) begin
                if (mCol > target) kind = 1;
                else if (mCol < target) kind = 2;
                else kind = 1 + int'($urandom % 2); // Jitter around the target
            end else begin
                kind = 0;
            end
            doCommand(kind);
            if (mLocked) target = int'($urandom % 10);
        end
        $display("%0d games ended, %0d lines in the last one", games, mLines);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tetrisTop.sv ====
`timescale 1ns/10ps

module tetrisTop import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [5:0] adr,
    input logic [31:0] datW,
    output logic [31:0] datR,
    output logic ack
);

    cmdT cmd;
    logic busy, gameOver, spawn, lock, moveEn;
    logic blocked, spawnFit, clearDone;
    logic [15:0] lines;
    pieceT piece, nextPiece;
    posT pos;
    boardT pieceView, settled, lockedBoard;

    wbRegs i_wbRegs (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack), .cmd(cmd), .busy(busy),
        .gameOver(gameOver), .piece(piece), .pos(pos), .lines(lines),
        .pieceView(pieceView)
    );

    gameCtrl i_gameCtrl (
        .clk(clk), .rst(rst), .cmd(cmd), .blocked(blocked), .clearDone(clearDone),
        .spawnFit(spawnFit), .spawn(spawn), .lock(lock), .busy(busy),
        .gameOver(gameOver), .moveEn(moveEn)
    );

    pieceGen i_pieceGen (
        .clk(clk), .rst(rst), .restart(cmd.restart), .advance(spawn),
        .nextPiece(nextPiece)
    );

    pieceDrop i_pieceDrop (
        .clk(clk), .rst(rst), .cmd(cmd), .moveEn(moveEn), .spawn(spawn),
        .newPiece(nextPiece), .settled(settled), .piece(piece), .pos(pos),
        .blocked(blocked), .spawnFit(spawnFit), .pieceView(pieceView),
        .lockedBoard(lockedBoard)
    );

    lineClear i_lineClear (
        .clk(clk), .rst(rst), .restart(cmd.restart), .lock(lock),
        .lockedBoard(lockedBoard), .settled(settled), .clearDone(clearDone),
        .lines(lines)
    );

endmodule

// ==== wbRegs.sv ====
`timescale 1ns/10ps

module wbRegs import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [5:0] adr,
    input logic [31:0] datW,
    output logic [31:0] datR,
    output logic ack,
    output cmdT cmd,
    input logic busy,
    input logic gameOver,
    input pieceT piece,
    input posT pos,
    input logic [15:0] lines,
    input boardT pieceView
);

    logic request;
    logic [5:0] rowSel;
    logic [31:0] rdData;

    // No new request while the previous ack is out
    assign request = cyc && stb && !ack;
    assign rowSel = adr - regRowBase;

    always_comb begin
        rdData = '0;
        if (adr == regStatus) begin
            rdData[0] = busy;
            rdData[1] = gameOver;
            rdData[4:2] = piece;
            rdData[12:8] = pos.row;
            rdData[20:16] = pos.col;
        end else if (adr == regLines) begin
            rdData[15:0] = lines;
        end else if (adr >= regRowBase && rowSel < 6'(numRows)) begin
            rdData[numCols-1:0] = pieceView[rowSel[4:0]]; // Column 0 lands in bit 9
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
            cmd <= '0;
        end else begin
            ack <= request;
            cmd <= '0; // Commands last one cycle
            if (request && we && adr == regCtrl) begin
                cmd.step <= datW[0];
                cmd.left <= datW[1];
                cmd.right <= datW[2];
                cmd.restart <= datW[3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (request && !we) begin
            datR <= rdData;
        end
    end

endmodule

// ==== gameCtrl.sv ====
`timescale 1ns/10ps

module gameCtrl import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input cmdT cmd,
    input logic blocked,
    input logic clearDone,
    input logic spawnFit,
    output logic spawn,
    output logic lock,
    output logic busy,
    output logic gameOver,
    output logic moveEn
);

    typedef enum logic [2:0] {
        stateIdle, stateLock, stateClear, stateSpawn, stateOver
    } stateT;

    stateT state;

    // Reset goes straight to spawn so a piece is ready right away
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= stateSpawn;
        end else if (cmd.restart) begin
            state <= stateSpawn;
        end else begin
            case (state)
                stateIdle: begin
                    if (cmd.step && blocked) begin
                        state <= stateLock;
                    end
                end
                stateLock: state <= stateClear;
                stateClear: begin
                    if (clearDone) begin
                        state <= stateSpawn;
                    end
                end
                stateSpawn: state <= spawnFit ? stateIdle : stateOver;
                stateOver: state <= stateOver; // Only restart leaves
                default: state <= stateIdle;
            endcase
        end
    end

    assign spawn = (state == stateSpawn);
    assign lock = (state == stateLock);
    assign busy = (state == stateLock) || (state == stateClear) || (state == stateSpawn);
    assign gameOver = (state == stateOver);
    assign moveEn = (state == stateIdle); // Moves are dropped in every other state

endmodule

// ==== lineClear.sv ====
`timescale 1ns/10ps

module lineClear import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input logic restart,
    input logic lock,
    input boardT lockedBoard,
    output boardT settled,
    output logic clearDone,
    output logic [15:0] lines
);

    logic scanning;
    logic [4:0] rowIdx; // Row under test, bottom first
    logic rowFull;

    assign rowFull = &settled[rowIdx];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            settled <= '0;
            scanning <= 1'b0;
            rowIdx <= '0;
            clearDone <= 1'b0;
            lines <= '0;
        end else begin
            clearDone <= 1'b0;
            if (restart) begin
                settled <= '0;
                scanning <= 1'b0;
                lines <= '0;
            end else if (lock) begin
                settled <= lockedBoard;
                rowIdx <= 5'(numRows - 1);
                scanning <= 1'b1;
            end else if (scanning) begin
                if (rowFull) begin
                    // Drop everything above, then look at this row again
                    for (int r = numRows - 1; r > 0; r--) begin
                        if (r <= int'(rowIdx)) begin
                            settled[r] <= settled[r-1];
                        end
                    end
                    settled[0] <= '0;
                    lines <= lines + 16'd1;
                end else if (rowIdx == 5'd0) begin
                    scanning <= 1'b0;
                    clearDone <= 1'b1;
                end else begin
                    rowIdx <= rowIdx - 5'd1;
                end
            end
        end
    end

endmodule

// ==== pieceDrop.sv ====
`timescale 1ns/10ps

module pieceDrop import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input cmdT cmd,
    input logic moveEn,
    input logic spawn,
    input pieceT newPiece,
    input boardT settled,
    output pieceT piece,
    output posT pos,
    output logic blocked,
    output logic spawnFit,
    output boardT pieceView,
    output boardT lockedBoard
);

    logic valid; // Piece is on the board and not yet locked
    logic downFit, leftFit, rightFit;
    shapeT shape;
    boardT overlay;

    // True when every shape cell lands inside the board on a free cell
    function automatic logic fits(shapeT s, int row, int col, boardT board);
        logic ok;
        int br;
        int bc;
        ok = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = row + r;
                bc = col + c;
                if (s[r][c]) begin
                    if (br >= numRows || bc < 0 || bc >= numCols) begin
                        ok = 1'b0;
                    end else if (board[br][bc]) begin
                        ok = 1'b0;
                    end
                end
            end
        end
        return ok;
    endfunction

    function automatic boardT place(shapeT s, int row, int col);
        boardT b;
        int br;
        int bc;
        b = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                br = row + r;
                bc = col + c;
                if (s[r][c] && br < numRows && bc < numCols) begin
                    b[br][bc] = 1'b1;
                end
            end
        end
        return b;
    endfunction

    assign shape = shapeOf(piece);

    // Candidate positions for the three moves
    assign downFit = fits(shape, int'(pos.row) + 1, int'(pos.col), settled);
    assign leftFit = fits(shape, int'(pos.row), int'(pos.col) - 1, settled);
    assign rightFit = fits(shape, int'(pos.row), int'(pos.col) + 1, settled);
    assign spawnFit = fits(shapeOf(newPiece), 0, int'(spawnCol), settled);
    assign blocked = !downFit;

    assign overlay = place(shape, int'(pos.row), int'(pos.col));
    assign lockedBoard = settled | overlay;
    assign pieceView = valid ? lockedBoard : settled;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            piece <= pieceLine;
            pos <= '0;
            valid <= 1'b0;
        end else if (spawn) begin
            piece <= newPiece;
            pos.row <= 5'd0;
            pos.col <= {1'b0, spawnCol};
            valid <= 1'b1;
        end else if (cmd.restart) begin
            valid <= 1'b0;
        end else if (moveEn) begin
            if (cmd.step) begin
                if (downFit) begin
                    pos.row <= pos.row + 5'd1;
                end else begin
                    valid <= 1'b0; // Locks, the stack takes over the cells
                end
            end else if (cmd.left && leftFit) begin
                pos.col <= pos.col - 5'd1;
            end else if (cmd.right && rightFit) begin
                pos.col <= pos.col + 5'd1;
            end
        end
    end

endmodule

// ==== pieceGen.sv ====
`timescale 1ns/10ps

module pieceGen import tetrisPkg::*; (
    input logic clk,
    input logic rst,
    input logic restart,
    input logic advance,
    output pieceT nextPiece
);

    logic [15:0] lfsr;
    logic [15:0] lfsrNext;

    // Right shift with taps folded in on a one out
    assign lfsrNext = (lfsr >> 1) ^ (lfsr[0] ? lfsrTaps : 16'h0000);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lfsr <= lfsrSeed;
        end else if (restart) begin
            lfsr <= lfsrSeed;
        end else if (advance) begin
            lfsr <= lfsrNext;
        end
    end

    // Code 7 has no shape of its own
    assign nextPiece = (lfsr[2:0] == 3'd7) ? pieceLine : pieceT'(lfsr[2:0]);

endmodule

// ==== tetrisPkg.sv ====
package tetrisPkg;

    localparam int numRows = 20;
    localparam int numCols = 10;

    // Row 0 is the top row and column 0 is the leftmost bit
    typedef logic [0:numRows-1][0:numCols-1] boardT;

    typedef enum logic [2:0] {
        pieceLine, pieceSquare, pieceL, pieceRevL, pieceS, pieceZ, pieceTShape
    } pieceT;

    typedef logic [0:3][0:3] shapeT; // Bounding box, top-left anchored

    typedef struct packed {
        logic [4:0] row;
        logic [4:0] col;
    } posT;

    typedef struct packed {
        logic step;
        logic left;
        logic right;
        logic restart;
    } cmdT;

    localparam logic [3:0] spawnCol = 4'd3;

    localparam logic [5:0] regStatus = 6'd0;
    localparam logic [5:0] regCtrl = 6'd1;
    localparam logic [5:0] regLines = 6'd2;
    localparam logic [5:0] regRowBase = 6'd32;

    localparam logic [15:0] lfsrSeed = 16'hACE1;
    localparam logic [15:0] lfsrTaps = 16'hB400;

    function automatic shapeT shapeOf(pieceT p);
        shapeT s;
        case (p)
            pieceLine: s = {4'b1000, 4'b1000, 4'b1000, 4'b1000};
            pieceSquare: s = {4'b1100, 4'b1100, 4'b0000, 4'b0000};
            pieceL: s = {4'b1000, 4'b1000, 4'b1100, 4'b0000};
            pieceRevL: s = {4'b0100, 4'b0100, 4'b1100, 4'b0000};
            pieceS: s = {4'b0110, 4'b1100, 4'b0000, 4'b0000};
            pieceZ: s = {4'b1100, 4'b0110, 4'b0000, 4'b0000};
            pieceTShape: s = {4'b0100, 4'b1110, 4'b0000, 4'b0000};
            default: s = '0;
        endcase
        return s;
    endfunction

endpackage
